// File: design/csrPkg.sv
`default_nettype none

package csrPkg;

    localparam int TIMER_N = 20;

    // instruction classes and subtypes
    localparam logic [3:0] TYPE_PRIV = 4'd3;
    localparam logic [3:0] TYPE_LLW  = 4'd6;
    localparam logic [4:0] SUB_LOAD  = 5'd0;

    localparam logic [4:0] SUB_TRAP    = 5'd0;
    localparam logic [4:0] SUB_ERTN    = 5'd6;
    localparam logic [4:0] SUB_IDLE    = 5'd7;
    localparam logic [4:0] SUB_CSRRD   = 5'd8;
    localparam logic [4:0] SUB_CSRWR   = 5'd9;
    localparam logic [4:0] SUB_CSRXCHG = 5'd10;

    // exception codes
    localparam logic [5:0] ECODE_INT  = 6'h00;
    localparam logic [5:0] ECODE_ADE  = 6'h08;
    localparam logic [5:0] ECODE_SYS  = 6'h0b;
    localparam logic [5:0] ECODE_BRK  = 6'h0c;
    localparam logic [5:0] ECODE_INE  = 6'h0d;
    localparam logic [5:0] ECODE_TLBR = 6'h3f;
    localparam logic [8:0] ESUB_ADEF  = 9'h000;

    // CSR numbers
    localparam logic [13:0] CSR_CRMD      = 14'h000;
    localparam logic [13:0] CSR_PRMD      = 14'h001;
    localparam logic [13:0] CSR_EUEN      = 14'h002;
    localparam logic [13:0] CSR_ECFG      = 14'h004;
    localparam logic [13:0] CSR_ESTAT     = 14'h005;
    localparam logic [13:0] CSR_ERA       = 14'h006;
    localparam logic [13:0] CSR_BADV      = 14'h007;
    localparam logic [13:0] CSR_EENTRY    = 14'h00c;
    localparam logic [13:0] CSR_ASID      = 14'h018;
    localparam logic [13:0] CSR_CPUID     = 14'h020;
    localparam logic [13:0] CSR_SAVE0     = 14'h030;
    localparam logic [13:0] CSR_SAVE1     = 14'h031;
    localparam logic [13:0] CSR_SAVE2     = 14'h032;
    localparam logic [13:0] CSR_SAVE3     = 14'h033;
    localparam logic [13:0] CSR_TID       = 14'h040;
    localparam logic [13:0] CSR_TCFG      = 14'h041;
    localparam logic [13:0] CSR_TVAL      = 14'h042;
    localparam logic [13:0] CSR_TICLR     = 14'h044;
    localparam logic [13:0] CSR_LLBCTL    = 14'h060;
    localparam logic [13:0] CSR_TLBRENTRY = 14'h088;
    localparam logic [13:0] CSR_DMW0      = 14'h180;
    localparam logic [13:0] CSR_DMW1      = 14'h181;

    // PLV 0, IE 0, DA 1
    localparam logic [8:0]  CRMD_RESET = 9'h008;
    // bit 10 of ECFG is reserved
    localparam logic [12:0] ECFG_WMASK = 13'h1bff;
    // VSEG, PSEG, MAT, PLV3, PLV0
    localparam logic [31:0] DMW_WMASK  = 32'hee00_0039;
    localparam logic [7:0]  ASID_BITS  = 8'd10;

    // argument word, either a CSR number or an exception code pair
    typedef union packed {
        struct packed {
            logic [1:0]  pad;
            logic [13:0] num;
        } csr;
        struct packed {
            logic       pad;
            logic [8:0] esub;
            logic [5:0] ecode;
        } excp;
    } excpArg_t;

endpackage

`default_nettype wire

// File: design/csrControl.sv
`timescale 1ns/1ps
`default_nettype none

module csrControl import csrPkg::*; (
    input  wire           clk,
    input  wire           rstn,
    input  wire           pipeStall,
    input  wire           pipeFlush,
    input  wire [3:0]     instType,
    input  wire [4:0]     instSubtype,
    input  wire excpArg_t excpArg,
    input  wire           intPending,
    output logic          doWrite,
    output logic          doTrap,
    output logic          doErtn,
    output logic          doLl,
    output logic [5:0]    trapEcode,
    output logic [8:0]    trapEsub,
    output logic          flush,
    output logic          clkStall
);

    logic isPriv;
    logic isLlw;
    logic accept;
    logic privOp;
    logic enterIdle;

    assign isPriv = instType == TYPE_PRIV;
    assign isLlw  = (instType == TYPE_LLW) && (instSubtype == SUB_LOAD);
    assign accept = (isPriv || isLlw) && !pipeStall && !pipeFlush;

    // a pending interrupt preempts whatever the pipeline presents
    assign privOp = accept && isPriv && !intPending;
    assign doLl   = accept && isLlw && !intPending;

    always_comb
    begin
        doTrap    = intPending;
        doErtn    = 1'b0;
        doWrite   = 1'b0;
        enterIdle = 1'b0;
        if (privOp)
        begin
            case (instSubtype)
                SUB_TRAP:
                    doTrap = 1'b1;
                SUB_ERTN:
                    doErtn = 1'b1;
                SUB_IDLE:
                    enterIdle = 1'b1;
                SUB_CSRWR, SUB_CSRXCHG:
                    doWrite = 1'b1;
                // csrrd only reads, the mux is combinational
                default:
                    doWrite = 1'b0;
            endcase
        end
    end

    assign trapEcode = intPending ? ECODE_INT : excpArg.excp.ecode;
    assign trapEsub  = intPending ? 9'd0 : excpArg.excp.esub;

    assign flush = doTrap || doErtn;

    // clock held off from idle until an interrupt is taken
    always_ff @(posedge clk)
    begin
        if (!rstn)
            clkStall <= 1'b0;
        else if (intPending)
            clkStall <= 1'b0;
        else if (enterIdle)
            clkStall <= 1'b1;
    end

endmodule

`default_nettype wire

// File: design/csrRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module csrRegFile import csrPkg::*; (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire excpArg_t       excpArg,
    input  wire [31:0]          wrData,
    input  wire [31:0]          wrMask,
    input  wire [31:0]          inPc,
    input  wire [8:0]           hwInt,
    input  wire                 doWrite,
    input  wire                 doTrap,
    input  wire                 doErtn,
    input  wire                 doLl,
    input  wire [5:0]           trapEcode,
    input  wire [8:0]           trapEsub,
    input  wire [TIMER_N-1:0]   tval,
    input  wire                 timerInt,
    input  wire [31:0]          badvNext,
    output logic [31:0]         rdData,
    output logic                intPending,
    output logic [TIMER_N-1:0]  tcfg,
    output logic                tiClear,
    output logic [31:0]         era,
    output logic [31:0]         eentry,
    output logic [31:0]         tlbrentry,
    output logic [8:0]          crmd,
    output logic                llBit,
    output logic [9:0]          asid,
    output logic [31:0]         dmw0,
    output logic [31:0]         dmw1
);

    logic [13:0] csrNum;
    logic [2:0]  prmd;
    logic        euen;
    logic [12:0] ecfg;
    logic [1:0]  estatIs;
    logic [5:0]  estatEcode;
    logic [8:0]  estatEsub;
    logic [31:0] badv;
    logic [25:0] eentryBase;
    logic [25:0] tlbrBase;
    logic [31:0] save [0:3];
    logic [31:0] tid;
    logic        llbKlo;
    logic [12:0] pendBits;
    logic [31:0] estat;
    logic [31:0] wrValue;

    assign csrNum = excpArg.csr.num;

    // IPI, timer, reserved, hardware lines, software lines
    assign pendBits   = {hwInt[8], timerInt, 1'b0, hwInt[7:0], estatIs};
    assign estat      = {1'b0, estatEsub, estatEcode, 3'b000, pendBits};
    assign intPending = crmd[2] && |(pendBits & ecfg);

    assign eentry    = {eentryBase, 6'b0};
    assign tlbrentry = {tlbrBase, 6'b0};

    always_comb
    begin
        case (csrNum)
            CSR_CRMD:      rdData = {23'b0, crmd};
            CSR_PRMD:      rdData = {29'b0, prmd};
            CSR_EUEN:      rdData = {31'b0, euen};
            CSR_ECFG:      rdData = {19'b0, ecfg};
            CSR_ESTAT:     rdData = estat;
            CSR_ERA:       rdData = era;
            CSR_BADV:      rdData = badv;
            CSR_EENTRY:    rdData = eentry;
            CSR_ASID:      rdData = {8'b0, ASID_BITS, 6'b0, asid};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                rdData = save[csrNum[1:0]];
            CSR_TID:       rdData = tid;
            CSR_TCFG:      rdData = {{(32 - TIMER_N){1'b0}}, tcfg};
            CSR_TVAL:      rdData = {{(32 - TIMER_N){1'b0}}, tval};
            CSR_LLBCTL:    rdData = {29'b0, llbKlo, 1'b0, llBit};
            CSR_TLBRENTRY: rdData = tlbrentry;
            CSR_DMW0:      rdData = dmw0;
            CSR_DMW1:      rdData = dmw1;
            // CPUID and TICLR read as zero
            default:       rdData = 32'b0;
        endcase
    end

    // csrwr comes with an all-ones mask from the pipeline
    assign wrValue = (rdData & ~wrMask) | (wrData & wrMask);
    assign tiClear = doWrite && (csrNum == CSR_TICLR) && wrValue[0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd       <= CRMD_RESET;
            prmd       <= 3'b0;
            euen       <= 1'b0;
            ecfg       <= 13'b0;
            estatIs    <= 2'b0;
            estatEcode <= 6'b0;
            estatEsub  <= 9'b0;
            tcfg       <= '0;
            llBit      <= 1'b0;
            llbKlo     <= 1'b0;
            asid       <= 10'b0;
            dmw0       <= 32'b0;
            dmw1       <= 32'b0;
        end
        else if (doTrap)
        begin
            prmd       <= crmd[2:0];
            crmd[2:0]  <= 3'b0;
            estatEcode <= trapEcode;
            estatEsub  <= trapEsub;
            // refill runs untranslated
            if (trapEcode == ECODE_TLBR)
                crmd[4:3] <= 2'b01;
        end
        else if (doErtn)
        begin
            crmd[2:0] <= prmd;
            crmd[4:3] <= (estatEcode == ECODE_TLBR) ? 2'b10 : 2'b01;
            llbKlo    <= 1'b0;
            if (!llbKlo)
                llBit <= 1'b0;
        end
        else if (doLl)
            llBit <= 1'b1;
        else if (doWrite)
        begin
            case (csrNum)
                CSR_CRMD:
                begin
                    crmd[2:0] <= wrValue[2:0];
                    crmd[8:5] <= wrValue[8:5];
                    // DA and PG must stay exclusive
                    if (wrValue[4] ^ wrValue[3])
                        crmd[4:3] <= wrValue[4:3];
                end
                CSR_PRMD:  prmd <= wrValue[2:0];
                CSR_EUEN:  euen <= wrValue[0];
                CSR_ECFG:  ecfg <= wrValue[12:0] & ECFG_WMASK;
                CSR_ESTAT: estatIs <= wrValue[1:0];
                CSR_TCFG:  tcfg <= wrValue[TIMER_N-1:0];
                CSR_ASID:  asid <= wrValue[9:0];
                CSR_DMW0:  dmw0 <= wrValue & DMW_WMASK;
                CSR_DMW1:  dmw1 <= wrValue & DMW_WMASK;
                CSR_LLBCTL:
                begin
                    if (wrValue[1])
                        llBit <= 1'b0;
                    llbKlo <= wrValue[2];
                end
                default:   llbKlo <= llbKlo;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (doTrap)
        begin
            era  <= inPc;
            badv <= badvNext;
        end
        else if (doWrite)
        begin
            case (csrNum)
                CSR_ERA:       era <= wrValue;
                CSR_BADV:      badv <= wrValue;
                CSR_EENTRY:    eentryBase <= wrValue[31:6];
                CSR_TLBRENTRY: tlbrBase <= wrValue[31:6];
                CSR_TID:       tid <= wrValue;
                CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                    save[csrNum[1:0]] <= wrValue;
                default:       tid <= tid;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/csrTimer.sv
`timescale 1ns/1ps
`default_nettype none

module csrTimer import csrPkg::*; (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire [TIMER_N-1:0]   tcfg,
    input  wire                 tiClear,
    output logic [TIMER_N-1:0]  tval,
    output logic                timerInt
);

    logic [TIMER_N-1:0] tcfgLast;
    logic [TIMER_N-1:0] initVal;
    logic               enable;
    logic               periodic;
    logic               load;

    assign enable   = tcfg[0];
    assign periodic = tcfg[1];
    assign initVal  = {tcfg[TIMER_N-1:2], 2'b00};

    // a newly written configuration restarts the count
    assign load = enable && (tcfg != tcfgLast);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval     <= '0;
            timerInt <= 1'b0;
            tcfgLast <= '0;
        end
        else
        begin
            tcfgLast <= tcfg;
            // clear wins over a new expiry
            if (tiClear)
                timerInt <= 1'b0;
            else if (enable && tval == 1)
                timerInt <= 1'b1;
            if (load)
                tval <= initVal;
            else if (enable && tval != 0)
                tval <= tval - 1'b1;
            else if (enable && periodic)
                tval <= initVal;
        end
    end

endmodule

`default_nettype wire

// File: design/csrTrapVector.sv
`timescale 1ns/1ps
`default_nettype none

module csrTrapVector import csrPkg::*; (
    input  wire         doErtn,
    input  wire [5:0]   trapEcode,
    input  wire [8:0]   trapEsub,
    input  wire [31:0]  era,
    input  wire [31:0]  eentry,
    input  wire [31:0]  tlbrentry,
    input  wire [31:0]  inPc,
    input  wire [31:0]  evAddr,
    output logic [31:0] targetPc,
    output logic [31:0] badvNext
);

    logic fetchFault;

    // refill has its own entry
    always_comb
    begin
        if (doErtn)
            targetPc = era;
        else if (trapEcode == ECODE_TLBR)
            targetPc = tlbrentry;
        else
            targetPc = eentry;
    end

    // fetch address error reports the faulting pc itself
    assign fetchFault = (trapEcode == ECODE_ADE) && (trapEsub == ESUB_ADEF);
    assign badvNext   = fetchFault ? inPc : evAddr;

endmodule

`default_nettype wire

// File: design/csrUnit.sv
`timescale 1ns/1ps
`default_nettype none

module csrUnit import csrPkg::*; (
    input  wire           clk,
    input  wire           rstn,
    input  wire           pipeStall,
    input  wire           pipeFlush,
    input  wire [3:0]     instType,
    input  wire [4:0]     instSubtype,
    input  wire excpArg_t excpArg,
    input  wire [31:0]    wrData,
    input  wire [31:0]    wrMask,
    input  wire [31:0]    inPc,
    input  wire [31:0]    evAddr,
    input  wire [8:0]     hwInt,
    output logic [31:0]   rdData,
    output logic          flush,
    output logic [31:0]   targetPc,
    output logic          clkStall,
    output logic [8:0]    crmd,
    output logic          llBit,
    output logic [9:0]    asid,
    output logic [31:0]   dmw0,
    output logic [31:0]   dmw1
);

    logic               doWrite;
    logic               doTrap;
    logic               doErtn;
    logic               doLl;
    logic [5:0]         trapEcode;
    logic [8:0]         trapEsub;
    logic               intPending;
    logic [TIMER_N-1:0] tcfg;
    logic               tiClear;
    logic [TIMER_N-1:0] tval;
    logic               timerInt;
    logic [31:0]        era;
    logic [31:0]        eentry;
    logic [31:0]        tlbrentry;
    logic [31:0]        badvNext;

    csrControl i_control (
        .clk         (clk),
        .rstn        (rstn),
        .pipeStall   (pipeStall),
        .pipeFlush   (pipeFlush),
        .instType    (instType),
        .instSubtype (instSubtype),
        .excpArg     (excpArg),
        .intPending  (intPending),
        .doWrite     (doWrite),
        .doTrap      (doTrap),
        .doErtn      (doErtn),
        .doLl        (doLl),
        .trapEcode   (trapEcode),
        .trapEsub    (trapEsub),
        .flush       (flush),
        .clkStall    (clkStall)
    );

    csrRegFile i_regFile (
        .clk        (clk),
        .rstn       (rstn),
        .excpArg    (excpArg),
        .wrData     (wrData),
        .wrMask     (wrMask),
        .inPc       (inPc),
        .hwInt      (hwInt),
        .doWrite    (doWrite),
        .doTrap     (doTrap),
        .doErtn     (doErtn),
        .doLl       (doLl),
        .trapEcode  (trapEcode),
        .trapEsub   (trapEsub),
        .tval       (tval),
        .timerInt   (timerInt),
        .badvNext   (badvNext),
        .rdData     (rdData),
        .intPending (intPending),
        .tcfg       (tcfg),
        .tiClear    (tiClear),
        .era        (era),
        .eentry     (eentry),
        .tlbrentry  (tlbrentry),
        .crmd       (crmd),
        .llBit      (llBit),
        .asid       (asid),
        .dmw0       (dmw0),
        .dmw1       (dmw1)
    );

    csrTimer i_timer (
        .clk      (clk),
        .rstn     (rstn),
        .tcfg     (tcfg),
        .tiClear  (tiClear),
        .tval     (tval),
        .timerInt (timerInt)
    );

    csrTrapVector i_trapVector (
        .doErtn    (doErtn),
        .trapEcode (trapEcode),
        .trapEsub  (trapEsub),
        .era       (era),
        .eentry    (eentry),
        .tlbrentry (tlbrentry),
        .inPc      (inPc),
        .evAddr    (evAddr),
        .targetPc  (targetPc),
        .badvNext  (badvNext)
    );

endmodule

`default_nettype wire

// File: dv/csrChecker.sv
`timescale 1ns/1ps
`default_nettype none

module csrChecker (
    input  wire        clk,
    input  wire [1:0]  sampleMode,
    input  wire [7:0]  chk,
    input  wire [31:0] expRd,
    input  wire [31:0] expPc,
    input  wire [2:0]  expFlags,
    input  wire [8:0]  expCrmd,
    input  wire [31:0] expAux,
    input  wire [15:0] testNo,
    input  wire        failNote,
    input  wire [31:0] rdData,
    input  wire        flush,
    input  wire [31:0] targetPc,
    input  wire        clkStall,
    input  wire [8:0]  crmd,
    input  wire        llBit,
    input  wire [9:0]  asid,
    input  wire [31:0] dmw0,
    input  wire [31:0] dmw1,
    output int         testCount,
    output int         checkCount,
    output int         errCount
);

    logic [15:0] curTest;
    int          testChecks;
    int          testErrors;
    logic        sampleNow;

    // 1 every edge, 2 on flush, 3 once the clock stall drops
    assign sampleNow = (sampleMode == 2'd1)
        || (sampleMode == 2'd2 && flush)
        || (sampleMode == 2'd3 && !clkStall);

    initial
    begin
        curTest    = 16'd0;
        testChecks = 0;
        testErrors = 0;
        testCount  = 0;
        checkCount = 0;
        errCount   = 0;
    end

    task automatic compareValue(input string name, input logic [31:0] expVal,
        input logic [31:0] actVal);
        begin
            checkCount++;
            testChecks++;
            if (actVal !== expVal)
            begin
                errCount++;
                testErrors++;
                $display("Mismatch at time %0t: %s expected %0h, got %0h",
                    $time, name, expVal, actVal);
            end
        end
    endtask

    task automatic finishTest();
        begin
            testCount++;
            if (testErrors == 0)
                $display("test %0d passed, %0d checks", curTest, testChecks);
            else
                $display("test %0d failed, %0d errors in %0d checks",
                    curTest, testErrors, testChecks);
        end
    endtask

    always @(posedge clk)
    begin
        if (testNo != curTest)
        begin
            if (curTest != 16'd0)
                finishTest();
            curTest    = testNo;
            testChecks = 0;
            testErrors = 0;
        end
        if (failNote)
        begin
            errCount++;
            testErrors++;
        end
        if (sampleNow)
        begin
            if (chk[0])
                compareValue("rdData", expRd, rdData);
            if (chk[1])
                compareValue("flush", {31'b0, expFlags[0]}, {31'b0, flush});
            if (chk[2])
                compareValue("targetPc", expPc, targetPc);
            if (chk[3])
                compareValue("clkStall", {31'b0, expFlags[1]}, {31'b0, clkStall});
            if (chk[4])
                compareValue("crmd", {23'b0, expCrmd}, {23'b0, crmd});
            if (chk[5])
                compareValue("llBit", {31'b0, expFlags[2]}, {31'b0, llBit});
            if (chk[6])
                compareValue("asid", {22'b0, expAux[9:0]}, {22'b0, asid});
            if (chk[7])
            begin
                compareValue("dmw0", expAux, dmw0);
                // no case writes DMW1, so it keeps its reset value
                compareValue("dmw1", 32'h0, dmw1);
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/csrUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module csrUnitTb;

    localparam int WAIT_LIMIT = 100;

    logic        clk;
    logic        rstn;
    logic        pipeStall;
    logic        pipeFlush;
    logic [3:0]  instType;
    logic [4:0]  instSubtype;
    logic [15:0] excpArg;
    logic [31:0] wrData;
    logic [31:0] wrMask;
    logic [31:0] inPc;
    logic [31:0] evAddr;
    logic [8:0]  hwInt;
    logic [31:0] rdData;
    logic        flush;
    logic [31:0] targetPc;
    logic        clkStall;
    logic [8:0]  crmd;
    logic        llBit;
    logic [9:0]  asid;
    logic [31:0] dmw0;
    logic [31:0] dmw1;

    logic [1:0]  sampleMode;
    logic [7:0]  chk;
    logic [31:0] expRd;
    logic [31:0] expPc;
    logic [2:0]  expFlags;
    logic [8:0]  expCrmd;
    logic [31:0] expAux;
    logic [15:0] testNo;
    logic        failNote;
    int          testCount;
    int          checkCount;
    int          errCount;
    int          fd;

    csrUnit i_dut (
        .clk         (clk),
        .rstn        (rstn),
        .pipeStall   (pipeStall),
        .pipeFlush   (pipeFlush),
        .instType    (instType),
        .instSubtype (instSubtype),
        .excpArg     (excpArg),
        .wrData      (wrData),
        .wrMask      (wrMask),
        .inPc        (inPc),
        .evAddr      (evAddr),
        .hwInt       (hwInt),
        .rdData      (rdData),
        .flush       (flush),
        .targetPc    (targetPc),
        .clkStall    (clkStall),
        .crmd        (crmd),
        .llBit       (llBit),
        .asid        (asid),
        .dmw0        (dmw0),
        .dmw1        (dmw1)
    );

    csrChecker i_checker (
        .clk        (clk),
        .sampleMode (sampleMode),
        .chk        (chk),
        .expRd      (expRd),
        .expPc      (expPc),
        .expFlags   (expFlags),
        .expCrmd    (expCrmd),
        .expAux     (expAux),
        .testNo     (testNo),
        .failNote   (failNote),
        .rdData     (rdData),
        .flush      (flush),
        .targetPc   (targetPc),
        .clkStall   (clkStall),
        .crmd       (crmd),
        .llBit      (llBit),
        .asid       (asid),
        .dmw0       (dmw0),
        .dmw1       (dmw1),
        .testCount  (testCount),
        .checkCount (checkCount),
        .errCount   (errCount)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // counted by the checker on the next rising edge
    task automatic reportFailure();
        begin
            instType = 4'd0;
            failNote = 1'b1;
            @(negedge clk);
            failNote = 1'b0;
        end
    endtask

    // mode 2 waits for flush, mode 3 for clkStall to drop
    task automatic waitForEvent(input logic [1:0] mode);
        int   cycles;
        logic seen;
        begin
            sampleMode = mode;
            cycles = 0;
            seen = 1'b0;
            while (!seen && cycles < WAIT_LIMIT)
            begin
                @(posedge clk);
                cycles++;
                seen = (mode == 2'd2) ? flush : !clkStall;
            end
            @(negedge clk);
            sampleMode = 2'd0;
            if (!seen)
            begin
                $display("timeout in test %0d: no %s within %0d cycles", testNo,
                    (mode == 2'd2) ? "flush" : "wake from idle", WAIT_LIMIT);
                reportFailure();
            end
        end
    endtask

    task automatic runCases();
        string            kind;
        logic [8*200-1:0] rest;
        logic [31:0]      typ;
        logic [31:0]      sub;
        logic [31:0]      arg;
        logic [31:0]      wdat;
        logic [31:0]      wmsk;
        logic [31:0]      pc;
        logic [31:0]      ev;
        logic [31:0]      hw;
        logic [31:0]      chkIn;
        logic [31:0]      eRd;
        logic [31:0]      ePc;
        logic [31:0]      eFlags;
        logic [31:0]      eCrmd;
        logic [31:0]      eAux;
        int               tnum;
        int               n;
        begin
            while (!$feof(fd))
            begin
                n = $fscanf(fd, "%s", kind);
                if (n != 1)
                    break;
                if (kind == "#")
                begin
                    n = $fgets(rest, fd);
                    continue;
                end
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                    typ, sub, arg, wdat, wmsk, pc, ev, hw, chkIn, eRd, ePc, eFlags,
                    eCrmd, eAux, tnum);
                if (n != 15)
                begin
                    $display("case file line after test %0d is incomplete", testNo);
                    reportFailure();
                    break;
                end
                instType    = typ[3:0];
                instSubtype = sub[4:0];
                excpArg     = arg[15:0];
                wrData      = wdat;
                wrMask      = wmsk;
                inPc        = pc;
                evAddr      = ev;
                hwInt       = hw[8:0];
                chk         = chkIn[7:0];
                expRd       = eRd;
                expPc       = ePc;
                expFlags    = eFlags[2:0];
                expCrmd     = eCrmd[8:0];
                expAux      = eAux;
                testNo      = tnum[15:0];
                if (kind == "op")
                begin
                    sampleMode = 2'd1;
                    @(posedge clk);
                    @(negedge clk);
                    sampleMode = 2'd0;
                end
                else if (kind == "waitflush")
                    waitForEvent(2'd2);
                else if (kind == "waitwake")
                    waitForEvent(2'd3);
                else
                begin
                    $display("unknown operation kind %s in test %0d", kind, testNo);
                    reportFailure();
                end
            end
        end
    endtask

    initial
    begin
        rstn        = 1'b0;
        pipeStall   = 1'b0;
        pipeFlush   = 1'b0;
        instType    = 4'd0;
        instSubtype = 5'd0;
        excpArg     = 16'd0;
        wrData      = 32'd0;
        wrMask      = 32'd0;
        inPc        = 32'd0;
        evAddr      = 32'd0;
        hwInt       = 9'd0;
        sampleMode  = 2'd0;
        chk         = 8'd0;
        expRd       = 32'd0;
        expPc       = 32'd0;
        expFlags    = 3'd0;
        expCrmd     = 9'd0;
        expAux      = 32'd0;
        testNo      = 16'd0;
        failNote    = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        fd = $fopen("dv/csrCases.txt", "r");
        if (fd == 0)
            $display("could not open dv/csrCases.txt");
        else
        begin
            runCases();
            $fclose(fd);
        end

        instType   = 4'd0;
        sampleMode = 2'd0;
        testNo     = 16'd0;
        repeat (2) @(posedge clk);
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (fd != 0 && errCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/csrPkg.sv
design/csrControl.sv
design/csrRegFile.sv
design/csrTimer.sv
design/csrTrapVector.sv
design/csrUnit.sv
dv/csrChecker.sv
dv/csrUnitTb.sv

// File: Makefile
TOP = csrUnitTb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

obj_dir/V$(TOP): verilog.f design/*.sv dv/*.sv
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: dv/csrCases.txt
# kind type sub arg wrData wrMask inPc evAddr hwInt chk expRd expPc flags expCrmd expAux test
# chk: 0 rd 1 flush 2 pc 3 stall 4 crmd 5 llBit 6 asid 7 dmw0, flags: 0 flush 1 stall 2 llBit
op        3 09 0030 12345678 ffffffff 00000000 00000000 000 00 00000000 00000000 0 000 00000000 1
op        3 0a 0030 aaaa5555 0000ffff 00000000 00000000 000 01 12345678 00000000 0 000 00000000 1
op        3 08 0030 00000000 00000000 00000000 00000000 000 01 12345555 00000000 0 000 00000000 1
op        3 09 0018 000003a5 ffffffff 00000000 00000000 000 00 00000000 00000000 0 000 00000000 1
op        3 09 0180 9e0000ff ffffffff 00000000 00000000 000 40 00000000 00000000 0 000 000003a5 1
op        3 08 0180 00000000 00000000 00000000 00000000 000 81 8e000039 00000000 0 000 8e000039 1
op        3 08 0000 00000000 00000000 00000000 00000000 000 3b 00000008 00000000 0 008 00000000 2
op        3 09 0000 0000001f ffffffff 00000000 00000000 000 00 00000000 00000000 0 000 00000000 2
op        3 08 0000 00000000 00000000 00000000 00000000 000 11 0000000f 00000000 0 00f 00000000 2
op        3 09 0020 deadbeef ffffffff 00000000 00000000 000 00 00000000 00000000 0 000 00000000 2
op        3 08 0020 00000000 00000000 00000000 00000000 000 01 00000000 00000000 0 000 00000000 2
op        3 09 000c 1c000100 ffffffff 00000000 00000000 000 00 00000000 00000000 0 000 00000000 3
op        3 00 000b 00000000 00000000 1c000420 00000000 000 06 00000000 1c000100 1 000 00000000 3
op        3 08 0006 00000000 00000000 00000000 00000000 000 11 1c000420 00000000 0 008 00000000 3
op        3 08 0005 00000000 00000000 00000000 00000000 000 01 000b0000 00000000 0 000 00000000 3
op        3 08 0001 00000000 00000000 00000000 00000000 000 01 00000007 00000000 0 000 00000000 3
op        3 06 0000 00000000 00000000 00000000 00000000 000 06 00000000 1c000420 1 000 00000000 3
op        3 08 0000 00000000 00000000 00000000 00000000 000 13 0000000f 00000000 0 00f 00000000 3
op        3 09 0004 00000800 ffffffff 00000000 00000000 000 00 00000000 00000000 0 000 00000000 4
op        3 09 0041 00000021 ffffffff 00000000 00000000 000 00 00000000 00000000 0 000 00000000 4
waitflush 0 00 0000 00000000 00000000 1c000500 00000000 000 06 00000000 1c000100 1 000 00000000 4
op        3 08 0005 00000000 00000000 00000000 00000000 000 11 00000800 00000000 0 008 00000000 4
op        3 09 0044 00000001 ffffffff 00000000 00000000 000 00 00000000 00000000 0 000 00000000 4
op        3 09 0000 0000000c ffffffff 00000000 00000000 000 02 00000000 00000000 0 000 00000000 4
op        3 08 0005 00000000 00000000 00000000 00000000 000 13 00000000 00000000 0 00c 00000000 4
op        3 09 0004 00000004 ffffffff 00000000 00000000 000 00 00000000 00000000 0 000 00000000 5
op        3 07 0000 00000000 00000000 00000000 00000000 000 02 00000000 00000000 0 000 00000000 5
op        0 00 0000 00000000 00000000 00000000 00000000 000 08 00000000 00000000 2 000 00000000 5
waitwake  0 00 0000 00000000 00000000 1c000600 00000000 001 18 00000000 00000000 0 008 00000000 5
op        6 00 0000 00000000 00000000 00000000 00000000 000 00 00000000 00000000 0 000 00000000 5
op        3 06 0000 00000000 00000000 00000000 00000000 000 26 00000000 1c000600 5 000 00000000 5
op        6 00 0000 00000000 00000000 00000000 00000000 000 20 00000000 00000000 0 000 00000000 5
op        3 09 0060 00000004 ffffffff 00000000 00000000 000 20 00000000 00000000 4 000 00000000 5
op        3 06 0000 00000000 00000000 00000000 00000000 000 06 00000000 1c000600 1 000 00000000 5
op        3 08 0060 00000000 00000000 00000000 00000000 000 21 00000001 00000000 4 000 00000000 5
op        3 09 0088 1c008000 ffffffff 00000000 00000000 000 00 00000000 00000000 0 000 00000000 6
op        3 09 0000 00000010 ffffffff 00000000 00000000 000 00 00000000 00000000 0 000 00000000 6
op        3 00 003f 00000000 00000000 1c000700 00000000 000 16 00000000 1c008000 1 010 00000000 6
op        3 08 0000 00000000 00000000 00000000 00000000 000 11 00000008 00000000 0 008 00000000 6
op        3 00 0008 00000000 00000000 1c000800 0badf00d 000 06 00000000 1c000100 1 000 00000000 6
op        3 08 0007 00000000 00000000 00000000 00000000 000 01 1c000800 00000000 0 000 00000000 6
op        3 00 0048 00000000 00000000 1c000900 0badf00d 000 06 00000000 1c000100 1 000 00000000 6
op        3 08 0007 00000000 00000000 00000000 00000000 000 01 0badf00d 00000000 0 000 00000000 6
